// File: tr8_settings.svh
// lane count, input sample width and internal lane width for the 8-point transform.
`ifndef TR8_SETTINGS_SVH
`define TR8_SETTINGS_SVH

// number of lanes per sample.
`define TR8_LANES 8

// width of one signed input sample.
`define TR8_IN_W 16

// internal and output lane width.
// 16-bit input, coefficient sums of at most 8*89 per pass, no shifting.
`define TR8_W 28

`endif

// File: tr8_pkg.sv
// lane, input vector, output vector and mode types shared by the transform core.
`include "tr8_settings.svh"

package tr8_pkg;

  // one signed lane at internal width.
  typedef logic signed [`TR8_W-1:0] lane_t;

  // eight lanes, l0 sits in the lowest bits.
  typedef struct packed {
    lane_t l7;
    lane_t l6;
    lane_t l5;
    lane_t l4;
    lane_t l3;
    lane_t l2;
    lane_t l1;
    lane_t l0;
  } vec8_t;

  // eight input samples, same ordering as vec8_t.
  typedef struct packed {
    logic signed [`TR8_IN_W-1:0] l7;
    logic signed [`TR8_IN_W-1:0] l6;
    logic signed [`TR8_IN_W-1:0] l5;
    logic signed [`TR8_IN_W-1:0] l4;
    logic signed [`TR8_IN_W-1:0] l3;
    logic signed [`TR8_IN_W-1:0] l2;
    logic signed [`TR8_IN_W-1:0] l1;
    logic signed [`TR8_IN_W-1:0] l0;
  } in_vec8_t;

  // per-sample control, travels with the data.
  typedef struct packed {
    logic valid;
    logic inverse;
    logic skip;
  } tr8_mode_t;

endpackage

// File: premuat_8.sv
// 8-point coefficient reorder stage with forward and inverse lane maps.
`timescale 1ns/100ps

module premuat_8
  import tr8_pkg::*;
(
  input  logic  i_enable,
  input  logic  i_inverse,
  input  vec8_t i_data,
  output vec8_t o_data
);

  // lanes 0 and 7 never move.
  // only lanes 1 to 6 are overridden below.
  always_comb begin
    o_data = i_data;
    if (i_enable) begin
      if (i_inverse) begin
        // natural y order into even half then odd half.
        o_data.l1 = i_data.l2;
        o_data.l2 = i_data.l4;
        o_data.l3 = i_data.l6;
        o_data.l4 = i_data.l1;
        o_data.l5 = i_data.l3;
        o_data.l6 = i_data.l5;
      end else begin
        // grouped y0 y2 y4 y6 y1 y3 y5 y7 back to natural order.
        o_data.l1 = i_data.l4;
        o_data.l2 = i_data.l1;
        o_data.l3 = i_data.l5;
        o_data.l4 = i_data.l2;
        o_data.l5 = i_data.l6;
        o_data.l6 = i_data.l3;
      end
    end
  end

endmodule

// File: butterfly_8.sv
// sum and difference butterfly between mirrored lanes, forward and inverse.
`timescale 1ns/100ps

module butterfly_8
  import tr8_pkg::*;
(
  input  logic  i_enable,
  input  logic  i_inverse,
  input  vec8_t i_data,
  output vec8_t o_data
);

  always_comb begin
    o_data = i_data;
    if (i_enable) begin
      if (i_inverse) begin
        // E in lanes 0..3, O in lanes 4..7.
        // x_k = E_k + O_k and x_(7-k) = E_k - O_k.
        o_data.l0 = i_data.l0 + i_data.l4;
        o_data.l7 = i_data.l0 - i_data.l4;
        o_data.l1 = i_data.l1 + i_data.l5;
        o_data.l6 = i_data.l1 - i_data.l5;
        o_data.l2 = i_data.l2 + i_data.l6;
        o_data.l5 = i_data.l2 - i_data.l6;
        o_data.l3 = i_data.l3 + i_data.l7;
        o_data.l4 = i_data.l3 - i_data.l7;
      end else begin
        // even sums to the low half.
        o_data.l0 = i_data.l0 + i_data.l7;
        o_data.l1 = i_data.l1 + i_data.l6;
        o_data.l2 = i_data.l2 + i_data.l5;
        o_data.l3 = i_data.l3 + i_data.l4;
        // odd differences to the high half.
        o_data.l4 = i_data.l0 - i_data.l7;
        o_data.l5 = i_data.l1 - i_data.l6;
        o_data.l6 = i_data.l2 - i_data.l5;
        o_data.l7 = i_data.l3 - i_data.l4;
      end
    end
  end

endmodule

// File: mcm_8.sv
// registered even and odd constant multiply stage with mode pipeline and checks.
`timescale 1ns/100ps
`include "tr8_settings.svh"

module mcm_8
  import tr8_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_arst_n,
  input  logic      i_enable,
  input  tr8_mode_t i_mode,
  input  vec8_t     i_data,
  output tr8_mode_t o_mode,
  output vec8_t     o_data
);

  localparam int HALF = `TR8_LANES / 2;

  // rows give y0 y2 y4 y6 from e0..e3.
  localparam lane_t C_EVEN [HALF][HALF] = '{
    '{64,  64,  64,  64},
    '{83,  36, -36, -83},
    '{64, -64, -64,  64},
    '{36, -83,  83, -36}
  };

  // rows give y1 y3 y5 y7 from o0..o3.
  localparam lane_t C_ODD [HALF][HALF] = '{
    '{89,  75,  50,  18},
    '{75, -18, -89, -50},
    '{50, -89,  18,  75},
    '{18, -50,  75, -89}
  };

  lane_t in_lane   [`TR8_LANES];
  lane_t prod_lane [`TR8_LANES];
  logic [`TR8_LANES*`TR8_W-1:0] prod_flat;

  always_comb begin
    for (int k = 0; k < `TR8_LANES; k++) begin
      in_lane[k] = i_data[k*`TR8_W +: `TR8_W];
    end
  end

  // inverse reads the same tables transposed.
  always_comb begin
    for (int r = 0; r < HALF; r++) begin
      prod_lane[r]      = '0;
      prod_lane[r+HALF] = '0;
      for (int c = 0; c < HALF; c++) begin
        if (i_mode.inverse) begin
          prod_lane[r]      = prod_lane[r] + C_EVEN[c][r] * in_lane[c];
          prod_lane[r+HALF] = prod_lane[r+HALF] + C_ODD[c][r] * in_lane[c+HALF];
        end else begin
          prod_lane[r]      = prod_lane[r] + C_EVEN[r][c] * in_lane[c];
          prod_lane[r+HALF] = prod_lane[r+HALF] + C_ODD[r][c] * in_lane[c+HALF];
        end
      end
    end
    for (int k = 0; k < `TR8_LANES; k++) begin
      prod_flat[k*`TR8_W +: `TR8_W] = prod_lane[k];
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_mode <= '0;
      o_data <= '0;
    end else begin
      o_mode <= i_mode;
      // data only moves with a strobe.
      if (i_mode.valid) begin
        o_data <= i_enable ? vec8_t'(prod_flat) : i_data;
      end
    end
  end

  a_valid_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !$isunknown(o_mode.valid));

  // exactly one cycle from strobe in to strobe out.
  a_valid_rise: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_mode.valid |=> o_mode.valid);
  a_valid_fall: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !i_mode.valid |=> !o_mode.valid);

  a_data_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_mode.valid |-> !$isunknown(o_data));

endmodule

// File: tr8_core.sv
// top of the 8-point transform core: sign extension, stage chain, pipeline registers.
`timescale 1ns/100ps
`include "tr8_settings.svh"

module tr8_core
  import tr8_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_arst_n,
  input  logic     i_valid,
  input  logic     i_inverse,
  input  logic     i_skip,
  input  in_vec8_t i_data,
  output logic     o_valid,
  output vec8_t    o_data
);

  tr8_mode_t in_mode;
  tr8_mode_t s1_mode;
  tr8_mode_t s2_mode;
  vec8_t     ext_data;
  vec8_t     pre_perm_out;
  vec8_t     pre_bfly_out;
  vec8_t     s1_data;
  vec8_t     s2_data;
  vec8_t     post_bfly_out;
  vec8_t     post_perm_out;
  logic [`TR8_LANES*`TR8_W-1:0] ext_flat;

  assign in_mode = '{valid: i_valid, inverse: i_inverse, skip: i_skip};

  // sign-extend every sample to lane width.
  always_comb begin
    for (int k = 0; k < `TR8_LANES; k++) begin
      ext_flat[k*`TR8_W +: `TR8_W] = `TR8_W'(signed'(i_data[k*`TR8_IN_W +: `TR8_IN_W]));
    end
  end
  assign ext_data = vec8_t'(ext_flat);

  // inverse reorders first, forward splits into even and odd first.
  premuat_8 u_pre_perm (
    .i_enable  (in_mode.inverse & ~in_mode.skip),
    .i_inverse (1'b1),
    .i_data    (ext_data),
    .o_data    (pre_perm_out)
  );

  butterfly_8 u_pre_bfly (
    .i_enable  (~in_mode.inverse & ~in_mode.skip),
    .i_inverse (1'b0),
    .i_data    (pre_perm_out),
    .o_data    (pre_bfly_out)
  );

  // register 1.
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      s1_mode <= '0;
      s1_data <= '0;
    end else begin
      s1_mode <= in_mode;
      if (in_mode.valid) begin
        s1_data <= pre_bfly_out;
      end
    end
  end

  // register 2 lives inside the multiply stage.
  mcm_8 u_mcm (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_enable (~s1_mode.skip),
    .i_mode   (s1_mode),
    .i_data   (s1_data),
    .o_mode   (s2_mode),
    .o_data   (s2_data)
  );

  butterfly_8 u_post_bfly (
    .i_enable  (s2_mode.inverse & ~s2_mode.skip),
    .i_inverse (1'b1),
    .i_data    (s2_data),
    .o_data    (post_bfly_out)
  );

  premuat_8 u_post_perm (
    .i_enable  (~s2_mode.inverse & ~s2_mode.skip),
    .i_inverse (1'b0),
    .i_data    (post_bfly_out),
    .o_data    (post_perm_out)
  );

  // register 3, drives the outputs.
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
      o_data  <= '0;
    end else begin
      o_valid <= s2_mode.valid;
      if (s2_mode.valid) begin
        o_data <= post_perm_out;
      end
    end
  end

  // mode bits steer every later stage.
  a_mode_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_valid |-> !$isunknown({i_inverse, i_skip}));

endmodule

// File: tb_tr8.sv
// testbench with reference transform, directed and random stimulus, scoreboard and timeout.
`timescale 1ns/100ps
`include "tr8_settings.svh"

module tb_tr8
  import tr8_pkg::*;
;

  localparam int unsigned SEED = 32'hc0b9_50e0;
  // tests take roughly 600 cycles.
  localparam int MAX_CYCLES = 2000;

  // hevc 8-point matrix, row k gives output y_k.
  localparam int COEF [8][8] = '{
    '{64,  64,  64,  64,  64,  64,  64,  64},
    '{89,  75,  50,  18, -18, -50, -75, -89},
    '{83,  36, -36, -83, -83, -36,  36,  83},
    '{75, -18, -89, -50,  50,  89,  18, -75},
    '{64, -64, -64,  64,  64, -64, -64,  64},
    '{50, -89,  18,  75, -75, -18,  89, -50},
    '{36, -83,  83, -36, -36,  83, -83,  36},
    '{18, -50,  75, -89,  89, -75,  50, -18}
  };

  logic     i_clk;
  logic     i_arst_n;
  logic     i_valid;
  logic     i_inverse;
  logic     i_skip;
  in_vec8_t i_data;
  logic     o_valid;
  vec8_t    o_data;

  vec8_t exp_q [$];
  vec8_t mon_exp;
  int    cycles = 0;

  tr8_core DUT (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_valid   (i_valid),
    .i_inverse (i_inverse),
    .i_skip    (i_skip),
    .i_data    (i_data),
    .o_valid   (o_valid),
    .o_data    (o_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // y = C.x forward, x = C^T.y inverse, plain copy in skip.
  function automatic vec8_t ref_transform(input in_vec8_t x, input logic inverse,
                                          input logic skip);
    vec8_t  r;
    longint xs [`TR8_LANES];
    longint acc;
    r = '0;
    for (int n = 0; n < `TR8_LANES; n++) begin
      xs[n] = longint'($signed(x[n*`TR8_IN_W +: `TR8_IN_W]));
    end
    for (int k = 0; k < `TR8_LANES; k++) begin
      acc = 0;
      if (skip) begin
        acc = xs[k];
      end else begin
        for (int n = 0; n < `TR8_LANES; n++) begin
          acc += inverse ? longint'(COEF[n][k]) * xs[n] : longint'(COEF[k][n]) * xs[n];
        end
      end
      r[k*`TR8_W +: `TR8_W] = `TR8_W'(acc);
    end
    return r;
  endfunction

  task automatic check_value(input longint got, input longint exp, input string what);
    if (got != exp) begin
      $display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp);
      $display("Some tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // lanes 0..3 take lo, lanes 4..7 take hi.
  function automatic in_vec8_t split_vec(input int lo, input int hi);
    in_vec8_t v;
    for (int k = 0; k < `TR8_LANES; k++) begin
      v[k*`TR8_IN_W +: `TR8_IN_W] = (k < 4) ? `TR8_IN_W'(lo) : `TR8_IN_W'(hi);
    end
    return v;
  endfunction

  function automatic in_vec8_t random_vec();
    in_vec8_t v;
    for (int k = 0; k < `TR8_LANES; k++) begin
      v[k*`TR8_IN_W +: `TR8_IN_W] = `TR8_IN_W'($urandom());
    end
    return v;
  endfunction

  // small enough that the forward result still fits an input sample.
  function automatic in_vec8_t small_vec();
    in_vec8_t v;
    for (int k = 0; k < `TR8_LANES; k++) begin
      v[k*`TR8_IN_W +: `TR8_IN_W] = `TR8_IN_W'(int'($urandom() % 81) - 40);
    end
    return v;
  endfunction

  function automatic in_vec8_t narrow_vec(input vec8_t y);
    in_vec8_t v;
    for (int k = 0; k < `TR8_LANES; k++) begin
      v[k*`TR8_IN_W +: `TR8_IN_W] = `TR8_IN_W'(y[k*`TR8_W +: `TR8_W]);
    end
    return v;
  endfunction

  task automatic drive_sample(input in_vec8_t x, input logic inv, input logic skp);
    @(negedge i_clk);
    i_valid   = 1'b1;
    i_inverse = inv;
    i_skip    = skp;
    i_data    = x;
    exp_q.push_back(ref_transform(x, inv, skp));
  endtask

  task automatic drive_random_mode();
    drive_sample(random_vec(), 1'($urandom() % 2), 1'($urandom() % 2));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge i_clk);
      i_valid = 1'b0;
    end
  endtask

  // bounded wait for the pipeline to empty.
  task automatic drain_pipeline();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 20) begin
      idle_cycles(1);
      waited++;
    end
    idle_cycles(2);
  endtask

  // scoreboard, outputs read before the edge updates them.
  always @(posedge i_clk) begin
    if (i_arst_n && o_valid) begin
      if (exp_q.size() == 0) begin
        $display("o_valid high at %0t with no sample outstanding", $time);
        $display("Some tests failed");
        $fatal(1, "unexpected output");
      end else begin
        mon_exp = exp_q.pop_front();
        for (int k = 0; k < `TR8_LANES; k++) begin
          check_value(longint'($signed(o_data[k*`TR8_W +: `TR8_W])),
                      longint'($signed(mon_exp[k*`TR8_W +: `TR8_W])),
                      $sformatf("lane l%0d", k));
        end
      end
    end
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run did not finish within %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    in_vec8_t x;
    void'($urandom(SEED));
    i_arst_n  = 1'b0;
    i_valid   = 1'b0;
    i_inverse = 1'b0;
    i_skip    = 1'b0;
    i_data    = '0;
    repeat (4) @(negedge i_clk);
    i_arst_n = 1'b1;

    // quiet output before any strobe.
    repeat (5) begin
      @(negedge i_clk);
      check_value(longint'(o_valid), 0, "o_valid before first strobe");
    end

    // forward, directed then random.
    drive_sample(split_vec(100, 100), 1'b0, 1'b0);
    for (int p = 0; p < `TR8_LANES; p++) begin
      x = split_vec(0, 0);
      x[p*`TR8_IN_W +: `TR8_IN_W] = `TR8_IN_W'(256);
      drive_sample(x, 1'b0, 1'b0);
    end
    drive_sample(split_vec(32767, 32767), 1'b0, 1'b0);
    drive_sample(split_vec(-32768, -32768), 1'b0, 1'b0);
    drive_sample(split_vec(32767, -32768), 1'b0, 1'b0);
    repeat (40) drive_sample(random_vec(), 1'b0, 1'b0);
    drain_pipeline();

    // inverse, random and round trip of forward results.
    repeat (40) drive_sample(random_vec(), 1'b1, 1'b0);
    repeat (10) begin
      x = small_vec();
      drive_sample(x, 1'b0, 1'b0);
      drive_sample(narrow_vec(ref_transform(x, 1'b0, 1'b0)), 1'b1, 1'b0);
    end
    drain_pipeline();

    // skip ignores the inverse control.
    repeat (20) drive_sample(random_vec(), 1'($urandom() % 2), 1'b1);
    drain_pipeline();

    // mixed modes, back to back with random gaps.
    repeat (200) begin
      if ($urandom() % 4 == 0) begin
        idle_cycles(1 + int'($urandom() % 3));
      end
      drive_random_mode();
    end
    drain_pipeline();

    // reset pulse in the middle of a stream.
    repeat (6) drive_random_mode();
    @(negedge i_clk);
    i_arst_n = 1'b0;
    i_valid  = 1'b0;
    exp_q.delete();
    repeat (2) @(negedge i_clk);
    i_arst_n = 1'b1;
    idle_cycles(3);
    repeat (12) drive_random_mode();
    drain_pipeline();

    if (exp_q.size() != 0) begin
      $display("%0d expected results never appeared on the output", exp_q.size());
      $display("Some tests failed");
      $fatal(1, "missing output");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

// File: flist.f
+incdir+.
tr8_pkg.sv
premuat_8.sv
butterfly_8.sv
mcm_8.sv
tr8_core.sv
tb_tr8.sv

// File: Makefile
TOP := tb_tr8
RTL := tr8_pkg.sv premuat_8.sv butterfly_8.sv mcm_8.sv tr8_core.sv

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): flist.f tr8_settings.svh $(RTL) tb_tr8.sv
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f

lint:
	verilator --lint-only -Wall +incdir+. --top-module tr8_core $(RTL)

clean:
	rm -rf obj_dir
